// ==== rtl/kernel_helper_pkg.sv ====
`default_nettype none

package kernel_helper_pkg;

   // ==================================================
   // Control bus widths
   // ==================================================
   localparam int AXIL_ADDR_W = 32;               // Host side address
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;  // One strobe per byte

   // ==================================================
   // Special register offsets inside the helper half
   // ==================================================
   localparam int OFS_KERNEL_TYPE   = 'h10; // Read only
   localparam int OFS_RELEASE_LEVEL = 'h14; // Read only
   localparam int OFS_IRQ_SRC_LO    = 'h18; // Write only
   localparam int OFS_IRQ_SRC_HI    = 'h1C; // Write only
   localparam int OFS_CONTEXT       = 'h20; // Read and write

   // Kernel name occupies eight consecutive words from here
   localparam int OFS_NAME_BASE     = 'h30;
   localparam int NAME_WORDS        = 8;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // ==================================================
   // AXI-Lite channel payloads
   // ==================================================
   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      logic [AXIL_STRB_W-1:0] strb;
   } axil_w_t;

   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      logic [1:0]             resp;
   } axil_r_t;

   // Write response carries only the code
   typedef struct packed {
      logic [1:0] resp;
   } axil_b_t;

endpackage

`default_nettype wire

// ==== rtl/ctrl_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_router #(
   parameter int REG_RANGE_BIT = 17,
   parameter int CTRL_ADDR_W   = 16
) (
   input  wire                                       clk,
   input  wire                                       resetn,

   // Host side
   input  wire kernel_helper_pkg::axil_aw_t          host_aw,
   input  wire                                       host_aw_valid,
   output logic                                      host_aw_ready,
   input  wire kernel_helper_pkg::axil_w_t           host_w,
   input  wire                                       host_w_valid,
   output logic                                      host_w_ready,
   input  wire kernel_helper_pkg::axil_ar_t          host_ar,
   input  wire                                       host_ar_valid,
   output logic                                      host_ar_ready,
   output kernel_helper_pkg::axil_r_t                host_r,
   output logic                                      host_r_valid,
   input  wire                                       host_r_ready,
   output kernel_helper_pkg::axil_b_t                host_b,
   output logic                                      host_b_valid,
   input  wire                                       host_b_ready,

   // Kernel side
   output logic [CTRL_ADDR_W-1:0]                    krn_awaddr,
   output logic                                      krn_aw_valid,
   input  wire                                       krn_aw_ready,
   output kernel_helper_pkg::axil_w_t                krn_w,
   output logic                                      krn_w_valid,
   input  wire                                       krn_w_ready,
   output logic [CTRL_ADDR_W-1:0]                    krn_araddr,
   output logic                                      krn_ar_valid,
   input  wire                                       krn_ar_ready,
   input  wire kernel_helper_pkg::axil_r_t           krn_r,
   input  wire                                       krn_r_valid,
   output logic                                      krn_r_ready,
   input  wire kernel_helper_pkg::axil_b_t           krn_b,
   input  wire                                       krn_b_valid,
   output logic                                      krn_b_ready,

   // Register bank
   output logic                                      wr_hit,
   output logic [REG_RANGE_BIT-1:0]                  wr_ofs,
   output logic [kernel_helper_pkg::AXIL_DATA_W-1:0] wr_data,
   output logic                                      rd_hit,
   output logic [REG_RANGE_BIT-1:0]                  rd_ofs,
   input  wire [kernel_helper_pkg::AXIL_DATA_W-1:0]  rd_word
);

   logic helper_w; // Range bit of the write address
   logic helper_r;
   logic rd_busy;  // Read accepted by the kernel, response not yet taken

   assign helper_w = host_aw.addr[REG_RANGE_BIT];
   assign helper_r = host_ar.addr[REG_RANGE_BIT];

   // ==================================================
   // Write path
   // ==================================================
   // Helper accesses still go to the kernel, at an address it ignores
   assign krn_awaddr    = helper_w ? {CTRL_ADDR_W{1'b1}} : host_aw.addr[CTRL_ADDR_W-1:0];
   assign krn_aw_valid  = host_aw_valid;
   assign host_aw_ready = krn_aw_ready;
   assign krn_w         = host_w;
   assign krn_w_valid   = host_w_valid;
   assign host_w_ready  = krn_w_ready;
   assign host_b        = krn_b;        // Kernel answers every write
   assign host_b_valid  = krn_b_valid;
   assign krn_b_ready   = host_b_ready;

   assign wr_hit  = host_aw_valid & host_w_valid & helper_w;
   assign wr_ofs  = host_aw.addr[REG_RANGE_BIT-1:0];
   assign wr_data = host_w.data;

   // ==================================================
   // Read path
   // ==================================================
   assign krn_araddr    = helper_r ? {CTRL_ADDR_W{1'b1}} : host_ar.addr[CTRL_ADDR_W-1:0];
   assign krn_ar_valid  = host_ar_valid;
   assign host_ar_ready = krn_ar_ready;
   assign host_r_valid  = krn_r_valid;
   assign krn_r_ready   = host_r_ready;

   // Every ar valid cycle loads the read word
   // Kernel range reads present offset zero, which holds no register
   assign rd_hit = host_ar_valid;
   assign rd_ofs = helper_r ? host_ar.addr[REG_RANGE_BIT-1:0] : '0;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_busy <= 1'b0;
      end else if (host_ar_valid && krn_ar_ready) begin
         rd_busy <= 1'b1;
      end else if (krn_r_valid && host_r_ready) begin
         rd_busy <= 1'b0;
      end
   end

   always_comb begin
      host_r      = krn_r;
      host_r.data = krn_r.data | (rd_busy ? rd_word : '0); // Kernel returns zero on helper reads
   end

endmodule

`default_nettype wire

// ==== rtl/helper_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module helper_regs #(
   parameter int          REG_RANGE_BIT = 17,
   parameter logic [31:0] KERNEL_TYPE   = 32'h0000_ABCD,
   parameter logic [31:0] RELEASE_LEVEL = 32'h0000_0001,
   // Word 0 of the name sits in the low bits
   parameter logic [kernel_helper_pkg::NAME_WORDS*kernel_helper_pkg::AXIL_DATA_W-1:0]
                          KERNEL_NAME   = {{7{32'h2020_2020}}, 32'h7473_6574},
   parameter int          CTXW          = 9
) (
   input  wire                                       clk,
   input  wire                                       resetn,
   input  wire                                       wr_hit,
   input  wire [REG_RANGE_BIT-1:0]                   wr_ofs,
   input  wire [kernel_helper_pkg::AXIL_DATA_W-1:0]  wr_data,
   input  wire                                       rd_hit,
   input  wire [REG_RANGE_BIT-1:0]                   rd_ofs,
   output logic [kernel_helper_pkg::AXIL_DATA_W-1:0] rd_word,
   output logic [63:0]                               irq_src,
   output logic [CTXW-1:0]                           irq_ctx
);

   localparam int DW         = kernel_helper_pkg::AXIL_DATA_W;
   localparam int NAME_IDX_W = $clog2(kernel_helper_pkg::NAME_WORDS);

   // Name window bounds at offset width
   localparam logic [REG_RANGE_BIT-1:0] NAME_LO =
      REG_RANGE_BIT'(kernel_helper_pkg::OFS_NAME_BASE);
   localparam logic [REG_RANGE_BIT-1:0] NAME_HI =
      REG_RANGE_BIT'(kernel_helper_pkg::OFS_NAME_BASE + 4 * kernel_helper_pkg::NAME_WORDS);

   logic [DW-1:0]            ctx_q;
   logic [DW-1:0]            src_lo_q;
   logic [DW-1:0]            src_hi_q;
   logic [REG_RANGE_BIT-1:0] name_ofs;
   logic                     name_hit;
   logic [NAME_IDX_W-1:0]    name_idx;
   logic [DW-1:0]            rd_next;

   // ==================================================
   // Writable registers
   // ==================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         ctx_q    <= '0;
         src_lo_q <= '0;
         src_hi_q <= '0;
      end else if (wr_hit) begin
         case (wr_ofs)
            kernel_helper_pkg::OFS_CONTEXT:    ctx_q    <= wr_data;
            kernel_helper_pkg::OFS_IRQ_SRC_LO: src_lo_q <= wr_data;
            kernel_helper_pkg::OFS_IRQ_SRC_HI: src_hi_q <= wr_data;
            default: ;
         endcase
      end
   end

   assign irq_src = {src_hi_q, src_lo_q};
   assign irq_ctx = ctx_q[CTXW-1:0]; // Context id is the low CTXW bits

   // ==================================================
   // Read word
   // ==================================================
   always_comb begin
      name_ofs = rd_ofs - NAME_LO;
      name_hit = (rd_ofs >= NAME_LO) && (rd_ofs < NAME_HI) && (rd_ofs[1:0] == 2'b00);
      name_idx = name_ofs[NAME_IDX_W+1:2];

      // Interrupt source halves are write only and fall to default
      case (rd_ofs)
         kernel_helper_pkg::OFS_KERNEL_TYPE:   rd_next = KERNEL_TYPE;
         kernel_helper_pkg::OFS_RELEASE_LEVEL: rd_next = RELEASE_LEVEL;
         kernel_helper_pkg::OFS_CONTEXT:       rd_next = ctx_q;
         default: begin
            rd_next = name_hit ? KERNEL_NAME[name_idx*DW +: DW] : '0;
         end
      endcase
   end

   // Held until the next read request so the late kernel response can pick it up
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_word <= '0;
      end else if (rd_hit) begin
         rd_word <= rd_next;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/irq_handshake.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_handshake (
   input  wire  clk,
   input  wire  resetn,
   input  wire  interrupt_i,   // Level from the kernel
   output logic interrupt_req,
   input  wire  interrupt_ack
);

   logic seen_q;     // Current interrupt level already reported
   logic wait_ack_q; // Request sent, acknowledge outstanding

   // Request pulses on a rise and stays up while a pending wait blocks seen
   assign interrupt_req = interrupt_i & ~seen_q;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         seen_q     <= 1'b0;
         wait_ack_q <= 1'b0;
      end else begin
         wait_ack_q <= interrupt_req | (wait_ack_q & ~interrupt_ack);
         // Seen only sets once the previous request was acknowledged
         seen_q     <= interrupt_i & (seen_q | ~wait_ack_q);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/kernel_helper.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_helper #(
   parameter logic [31:0] KERNEL_TYPE   = 32'h0000_ABCD,
   parameter logic [31:0] RELEASE_LEVEL = 32'h0000_0001,
   parameter logic [kernel_helper_pkg::NAME_WORDS*kernel_helper_pkg::AXIL_DATA_W-1:0]
                          KERNEL_NAME   = {{7{32'h2020_2020}}, 32'h7473_6574},
   parameter int          REG_RANGE_BIT = 17, // Upper half of the kernel window
   parameter int          CTXW          = 9,
   parameter int          CTRL_ADDR_W   = 16  // Kernel control address width
) (
   input  wire                              clk,
   input  wire                              resetn,

   // Interrupt
   input  wire                              interrupt_i,
   output logic                             interrupt_req,
   output logic [63:0]                      interrupt_src,
   output logic [CTXW-1:0]                  interrupt_ctx,
   input  wire                              interrupt_ack,

   // Host side AXI-Lite slave
   input  wire kernel_helper_pkg::axil_aw_t host_aw,
   input  wire                              host_aw_valid,
   output logic                             host_aw_ready,
   input  wire kernel_helper_pkg::axil_w_t  host_w,
   input  wire                              host_w_valid,
   output logic                             host_w_ready,
   input  wire kernel_helper_pkg::axil_ar_t host_ar,
   input  wire                              host_ar_valid,
   output logic                             host_ar_ready,
   output kernel_helper_pkg::axil_r_t       host_r,
   output logic                             host_r_valid,
   input  wire                              host_r_ready,
   output kernel_helper_pkg::axil_b_t       host_b,
   output logic                             host_b_valid,
   input  wire                              host_b_ready,

   // Kernel side AXI-Lite master
   output logic [CTRL_ADDR_W-1:0]           krn_awaddr,
   output logic                             krn_aw_valid,
   input  wire                              krn_aw_ready,
   output kernel_helper_pkg::axil_w_t       krn_w,
   output logic                             krn_w_valid,
   input  wire                              krn_w_ready,
   output logic [CTRL_ADDR_W-1:0]           krn_araddr,
   output logic                             krn_ar_valid,
   input  wire                              krn_ar_ready,
   input  wire kernel_helper_pkg::axil_r_t  krn_r,
   input  wire                              krn_r_valid,
   output logic                             krn_r_ready,
   input  wire kernel_helper_pkg::axil_b_t  krn_b,
   input  wire                              krn_b_valid,
   output logic                             krn_b_ready
);

   logic                                  wr_hit;
   logic [REG_RANGE_BIT-1:0]              wr_ofs;
   logic [kernel_helper_pkg::AXIL_DATA_W-1:0] wr_data;
   logic                                  rd_hit;
   logic [REG_RANGE_BIT-1:0]              rd_ofs;
   logic [kernel_helper_pkg::AXIL_DATA_W-1:0] rd_word;

   ctrl_router #(
      .REG_RANGE_BIT (REG_RANGE_BIT),
      .CTRL_ADDR_W   (CTRL_ADDR_W)
   ) u_ctrl_router (
      .clk           (clk),
      .resetn        (resetn),
      .host_aw       (host_aw),
      .host_aw_valid (host_aw_valid),
      .host_aw_ready (host_aw_ready),
      .host_w        (host_w),
      .host_w_valid  (host_w_valid),
      .host_w_ready  (host_w_ready),
      .host_ar       (host_ar),
      .host_ar_valid (host_ar_valid),
      .host_ar_ready (host_ar_ready),
      .host_r        (host_r),
      .host_r_valid  (host_r_valid),
      .host_r_ready  (host_r_ready),
      .host_b        (host_b),
      .host_b_valid  (host_b_valid),
      .host_b_ready  (host_b_ready),
      .krn_awaddr    (krn_awaddr),
      .krn_aw_valid  (krn_aw_valid),
      .krn_aw_ready  (krn_aw_ready),
      .krn_w         (krn_w),
      .krn_w_valid   (krn_w_valid),
      .krn_w_ready   (krn_w_ready),
      .krn_araddr    (krn_araddr),
      .krn_ar_valid  (krn_ar_valid),
      .krn_ar_ready  (krn_ar_ready),
      .krn_r         (krn_r),
      .krn_r_valid   (krn_r_valid),
      .krn_r_ready   (krn_r_ready),
      .krn_b         (krn_b),
      .krn_b_valid   (krn_b_valid),
      .krn_b_ready   (krn_b_ready),
      .wr_hit        (wr_hit),
      .wr_ofs        (wr_ofs),
      .wr_data       (wr_data),
      .rd_hit        (rd_hit),
      .rd_ofs        (rd_ofs),
      .rd_word       (rd_word)
   );

   helper_regs #(
      .REG_RANGE_BIT (REG_RANGE_BIT),
      .KERNEL_TYPE   (KERNEL_TYPE),
      .RELEASE_LEVEL (RELEASE_LEVEL),
      .KERNEL_NAME   (KERNEL_NAME),
      .CTXW          (CTXW)
   ) u_helper_regs (
      .clk     (clk),
      .resetn  (resetn),
      .wr_hit  (wr_hit),
      .wr_ofs  (wr_ofs),
      .wr_data (wr_data),
      .rd_hit  (rd_hit),
      .rd_ofs  (rd_ofs),
      .rd_word (rd_word),
      .irq_src (interrupt_src),
      .irq_ctx (interrupt_ctx)
   );

   irq_handshake u_irq_handshake (
      .clk           (clk),
      .resetn        (resetn),
      .interrupt_i   (interrupt_i),
      .interrupt_req (interrupt_req),
      .interrupt_ack (interrupt_ack)
   );

endmodule

`default_nettype wire

// ==== tests/tb_kernel_helper.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_kernel_helper;

   localparam int CLK_PERIOD = 20;
   localparam int SAMPLE_DLY = CLK_PERIOD / 4; // Inputs settled before the next rising edge
   localparam int RRB        = 17;             // Helper range bit
   localparam int CTXW       = 9;
   localparam int CAW        = 16;
   localparam logic [31:0]  KTYPE   = 32'h5A17_0C3E;
   localparam logic [31:0]  RELEASE = 32'h0002_0105;
   localparam logic [255:0] NAME    = {32'h0000_0000, 32'h0000_0033, 32'h765F_6C65,
                                       32'h6E72_656B, 32'h5F6C_6563, 32'h6361_2D61,
                                       32'h6E6F_6D31, 32'h6465_6D6F};

   localparam int N_KRN      = 20; // Kernel range write and read pairs
   localparam int N_REG      = 10; // Rounds of context and interrupt source traffic
   localparam int N_UNMAPPED = 6;
   localparam int N_TRANS    = 2 * N_KRN + 2 + kernel_helper_pkg::NAME_WORDS + N_UNMAPPED
                               + 2 * N_REG + 4 * N_REG;
   localparam int TIMEOUT_CYCLES = 200 * N_TRANS + 1000;
   localparam logic [RRB-1:0] UNMAPPED [N_UNMAPPED] =
      '{17'h00000, 17'h0000C, 17'h00024, 17'h00032, 17'h00050, 17'h1FFFC};

   logic clk, resetn;
   logic interrupt_i, interrupt_ack, interrupt_req;
   logic [63:0] interrupt_src;
   logic [CTXW-1:0] interrupt_ctx;
   kernel_helper_pkg::axil_aw_t host_aw;
   kernel_helper_pkg::axil_w_t  host_w, krn_w;
   kernel_helper_pkg::axil_ar_t host_ar;
   kernel_helper_pkg::axil_r_t  host_r, krn_r;
   kernel_helper_pkg::axil_b_t  host_b, krn_b;
   logic host_aw_valid, host_aw_ready, host_w_valid, host_w_ready;
   logic host_ar_valid, host_ar_ready, host_r_valid, host_r_ready, host_b_valid, host_b_ready;
   logic [CAW-1:0] krn_awaddr, krn_araddr;
   logic krn_aw_valid, krn_aw_ready, krn_w_valid, krn_w_ready;
   logic krn_ar_valid, krn_ar_ready, krn_r_valid, krn_r_ready, krn_b_valid, krn_b_ready;

   int value_errors, protocol_errors, cycle_cnt, pending_rises;
   int n_writes, n_reads, krn_aw_cnt, krn_w_cnt, krn_b_cnt, krn_ar_cnt, krn_r_cnt;
   logic [CAW-1:0] awaddr_q[$];
   logic [CAW-1:0] araddr_q[$];
   logic [31:0] wdata_q[$];
   logic [3:0] wstrb_q[$];
   logic [31:0] rdata_q[$];  // Data the kernel model returned in order
   logic [31:0] ctx_m;
   logic [63:0] src_m;

   kernel_helper #(
      .KERNEL_TYPE   (KTYPE),
      .RELEASE_LEVEL (RELEASE),
      .KERNEL_NAME   (NAME),
      .REG_RANGE_BIT (RRB),
      .CTXW          (CTXW),
      .CTRL_ADDR_W   (CAW)
   ) u_kernel_helper (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Run stopped by timeout after %0d cycles", cycle_cnt);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
      $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      value_errors++;
   endtask

   task automatic protocol_error(input string what);
      $display("Failure at %0t: %s", $time, what);
      protocol_errors++;
   endtask

   // Expected helper word by offset
   function automatic logic [31:0] reg_model(input logic [RRB-1:0] ofs);
      if (ofs == RRB'(kernel_helper_pkg::OFS_KERNEL_TYPE)) return KTYPE;
      if (ofs == RRB'(kernel_helper_pkg::OFS_RELEASE_LEVEL)) return RELEASE;
      if (ofs == RRB'(kernel_helper_pkg::OFS_CONTEXT)) return ctx_m;
      for (int i = 0; i < kernel_helper_pkg::NAME_WORDS; i++) begin
         if (ofs == RRB'(kernel_helper_pkg::OFS_NAME_BASE + 4 * i)) return NAME[i*32 +: 32];
      end
      return 32'h0; // Write-only source words and unmapped offsets
   endfunction

   function automatic logic [31:0] kernel_addr();
      logic [31:0] a;
      a = $urandom; // Random upper bits exercise the truncation
      a[RRB] = 1'b0;
      a[1:0] = 2'b00;
      return a;
   endfunction

   function automatic logic [31:0] helper_addr(input logic [RRB-1:0] ofs);
      logic [31:0] a;
      a = $urandom;
      a[RRB] = 1'b1;
      a[RRB-1:0] = ofs;
      return a;
   endfunction

   // ==================================================
   // Host side transactions
   // ==================================================
   task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
      logic aw_done, w_done, b_done;
      logic [CAW-1:0] exp_addr;
      logic [3:0] strb;
      aw_done = 1'b0;
      w_done = 1'b0;
      b_done = 1'b0;
      exp_addr = addr[RRB] ? {CAW{1'b1}} : addr[CAW-1:0];
      strb = '1;
      if (!addr[RRB]) strb = 4'($urandom); // Kernel range writes also carry partial strobes
      @(negedge clk);
      host_aw.addr = addr;
      host_w.data = data;
      host_w.strb = strb;
      host_aw_valid = 1'b1;
      host_w_valid = 1'b1;
      while (!(aw_done && w_done)) begin
         #(SAMPLE_DLY);
         if (host_aw_valid && host_aw_ready) aw_done = 1'b1;
         if (host_w_valid && host_w_ready) w_done = 1'b1;
         @(negedge clk);
         if (aw_done) host_aw_valid = 1'b0;
         if (w_done) host_w_valid = 1'b0;
      end
      host_b_ready = 1'b1;
      while (!b_done) begin
         #(SAMPLE_DLY);
         if (host_b_valid) begin
            b_done = 1'b1;
            if (host_b.resp !== kernel_helper_pkg::RESP_OKAY)
               value_error("host_b.resp", 64'(host_b.resp), 64'(kernel_helper_pkg::RESP_OKAY));
         end
         @(negedge clk);
      end
      host_b_ready = 1'b0;
      n_writes++;
      if (addr[RRB]) begin
         case (addr[RRB-1:0])
            RRB'(kernel_helper_pkg::OFS_CONTEXT):    ctx_m = data;
            RRB'(kernel_helper_pkg::OFS_IRQ_SRC_LO): src_m[31:0] = data;
            RRB'(kernel_helper_pkg::OFS_IRQ_SRC_HI): src_m[63:32] = data;
            default: ;
         endcase
      end
      if (awaddr_q.size() == 0 || wdata_q.size() == 0) begin
         protocol_error("host write did not reach the kernel");
      end else begin
         if (awaddr_q[0] !== exp_addr) value_error("krn_awaddr", 64'(awaddr_q[0]), 64'(exp_addr));
         if (wdata_q[0] !== data) value_error("krn_w.data", 64'(wdata_q[0]), 64'(data));
         if (wstrb_q[0] !== strb) value_error("krn_w.strb", 64'(wstrb_q[0]), 64'(strb));
         void'(awaddr_q.pop_front());
         void'(wdata_q.pop_front());
         void'(wstrb_q.pop_front());
      end
      if (interrupt_ctx !== ctx_m[CTXW-1:0])
         value_error("interrupt_ctx", 64'(interrupt_ctx), 64'(ctx_m[CTXW-1:0]));
      if (interrupt_src !== src_m) value_error("interrupt_src", interrupt_src, src_m);
   endtask

   task automatic host_read(input logic [31:0] addr);
      logic ar_done, r_done;
      logic [31:0] got, exp;
      logic [CAW-1:0] exp_addr;
      ar_done = 1'b0;
      r_done = 1'b0;
      got = '0;
      exp_addr = addr[RRB] ? {CAW{1'b1}} : addr[CAW-1:0];
      @(negedge clk);
      host_ar.addr = addr;
      host_ar_valid = 1'b1;
      while (!ar_done) begin
         #(SAMPLE_DLY);
         if (host_ar_ready) ar_done = 1'b1;
         @(negedge clk);
         if (ar_done) host_ar_valid = 1'b0;
      end
      host_r_ready = 1'b1;
      while (!r_done) begin
         #(SAMPLE_DLY);
         if (host_r_valid) begin
            r_done = 1'b1;
            got = host_r.data;
            if (host_r.resp !== kernel_helper_pkg::RESP_OKAY)
               value_error("host_r.resp", 64'(host_r.resp), 64'(kernel_helper_pkg::RESP_OKAY));
         end
         @(negedge clk);
      end
      host_r_ready = 1'b0;
      n_reads++;
      if (araddr_q.size() == 0 || rdata_q.size() == 0) begin
         protocol_error("host read did not reach the kernel");
      end else begin
         exp = addr[RRB] ? (rdata_q[0] | reg_model(addr[RRB-1:0])) : rdata_q[0];
         if (araddr_q[0] !== exp_addr) value_error("krn_araddr", 64'(araddr_q[0]), 64'(exp_addr));
         if (got !== exp) value_error("host_r.data", 64'(got), 64'(exp));
         void'(araddr_q.pop_front());
         void'(rdata_q.pop_front());
      end
   endtask

   // ==================================================
   // Kernel responder model
   // ==================================================
   initial begin : kernel_responder
      logic aw_got, w_got, b_taken, r_taken;
      int r_wait;
      logic [31:0] r_next;
      {aw_got, w_got, b_taken, r_taken} = 4'b0000;
      r_wait = 0;
      r_next = '0;
      {krn_aw_ready, krn_w_ready, krn_ar_ready, krn_r_valid, krn_b_valid} = 5'b00000;
      krn_r = '0;
      krn_b = '0;
      forever begin
         @(negedge clk);
         if (b_taken) krn_b_valid = 1'b0;
         if (r_taken) krn_r_valid = 1'b0;
         if (aw_got && w_got) begin // Both halves of the write seen
            krn_b_valid = 1'b1;
            krn_b.resp = kernel_helper_pkg::RESP_OKAY;
            aw_got = 1'b0;
            w_got = 1'b0;
         end
         if (r_wait > 0) begin
            r_wait--;
            if (r_wait == 0) begin
               krn_r_valid = 1'b1;
               krn_r.data = r_next;
               krn_r.resp = kernel_helper_pkg::RESP_OKAY;
               rdata_q.push_back(r_next);
            end
         end
         krn_aw_ready = ($urandom % 3) != 0;
         krn_w_ready = ($urandom % 3) != 0;
         krn_ar_ready = ($urandom % 3) != 0;
         #(SAMPLE_DLY);
         if (krn_aw_valid !== host_aw_valid || host_aw_ready !== krn_aw_ready ||
             krn_w_valid !== host_w_valid || host_w_ready !== krn_w_ready ||
             krn_ar_valid !== host_ar_valid || host_ar_ready !== krn_ar_ready ||
             host_r_valid !== krn_r_valid || krn_r_ready !== host_r_ready ||
             host_b_valid !== krn_b_valid || krn_b_ready !== host_b_ready)
            protocol_error("valid or ready bit not passed straight between host and kernel");
         if (krn_aw_valid && krn_aw_ready) begin
            awaddr_q.push_back(krn_awaddr);
            aw_got = 1'b1;
            krn_aw_cnt++;
         end
         if (krn_w_valid && krn_w_ready) begin
            wdata_q.push_back(krn_w.data);
            wstrb_q.push_back(krn_w.strb);
            w_got = 1'b1;
            krn_w_cnt++;
         end
         if (krn_ar_valid && krn_ar_ready) begin
            araddr_q.push_back(krn_araddr);
            r_wait = 1 + int'($urandom % 3); // Response one to three cycles later
            r_next = (krn_araddr == {CAW{1'b1}}) ? 32'h0 : $urandom;
            krn_ar_cnt++;
         end
         b_taken = krn_b_valid && krn_b_ready;
         r_taken = krn_r_valid && krn_r_ready;
         if (b_taken) krn_b_cnt++;
         if (r_taken) krn_r_cnt++;
      end
   end

   // Interrupt stimulus and reference model, checked every cycle
   initial begin : irq_model
      logic seen_m, wait_m, req_m, seen_n;
      {seen_m, wait_m, req_m, seen_n} = 4'b0000;
      interrupt_i = 1'b0;
      interrupt_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (($urandom % 5) == 0) interrupt_i = ~interrupt_i;
         interrupt_ack = ($urandom % 6) == 0;
         #(SAMPLE_DLY);
         req_m = interrupt_i && !seen_m;
         if (interrupt_req !== req_m) value_error("interrupt_req", 64'(interrupt_req), 64'(req_m));
         if (req_m && wait_m) pending_rises++;
         if (!resetn) begin
            seen_m = 1'b0;
            wait_m = 1'b0;
         end else begin
            if (!interrupt_i) seen_n = 1'b0;
            else if (!wait_m) seen_n = 1'b1;
            else seen_n = seen_m;          // Held clear while an ack is pending
            if (req_m) wait_m = 1'b1;
            else if (interrupt_ack) wait_m = 1'b0;
            seen_m = seen_n;
         end
      end
   end

   // ==================================================
   // Test sequence
   // ==================================================
   initial begin : main_sequence
      void'($urandom(32'had8c_6219));
      resetn = 1'b0;
      host_aw = '0;
      host_w = '0;
      host_ar = '0;
      {host_aw_valid, host_w_valid, host_ar_valid, host_r_ready, host_b_ready} = 5'b00000;
      ctx_m = '0;
      src_m = '0;
      repeat (4) @(negedge clk);
      resetn = 1'b1;

      for (int i = 0; i < N_KRN; i++) begin
         host_write(kernel_addr(), $urandom);
         host_read(kernel_addr());
      end
      host_read(helper_addr(RRB'(kernel_helper_pkg::OFS_KERNEL_TYPE)));
      host_read(helper_addr(RRB'(kernel_helper_pkg::OFS_RELEASE_LEVEL)));
      for (int i = 0; i < kernel_helper_pkg::NAME_WORDS; i++)
         host_read(helper_addr(RRB'(kernel_helper_pkg::OFS_NAME_BASE + 4 * i)));
      foreach (UNMAPPED[i]) host_read(helper_addr(UNMAPPED[i]));
      for (int i = 0; i < N_REG; i++) begin
         host_write(helper_addr(RRB'(kernel_helper_pkg::OFS_CONTEXT)), $urandom);
         host_read(helper_addr(RRB'(kernel_helper_pkg::OFS_CONTEXT)));
      end
      for (int i = 0; i < N_REG; i++) begin
         host_write(helper_addr(RRB'(kernel_helper_pkg::OFS_IRQ_SRC_LO)), $urandom);
         host_write(helper_addr(RRB'(kernel_helper_pkg::OFS_IRQ_SRC_HI)), $urandom);
         host_read(helper_addr(RRB'(kernel_helper_pkg::OFS_IRQ_SRC_LO)));
         host_read(helper_addr(RRB'(kernel_helper_pkg::OFS_IRQ_SRC_HI)));
      end

      repeat (10) @(negedge clk);
      if (krn_aw_cnt != n_writes || krn_w_cnt != n_writes || krn_b_cnt != n_writes)
         protocol_error($sformatf("write transfers lost or duplicated, host %0d kernel %0d/%0d/%0d",
                                  n_writes, krn_aw_cnt, krn_w_cnt, krn_b_cnt));
      if (krn_ar_cnt != n_reads || krn_r_cnt != n_reads)
         protocol_error($sformatf("read transfers lost or duplicated, host %0d kernel %0d/%0d",
                                  n_reads, krn_ar_cnt, krn_r_cnt));
      if (pending_rises == 0) protocol_error("no interrupt request arrived during a pending wait");
      $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/kernel_helper_pkg.sv
rtl/ctrl_router.sv
rtl/helper_regs.sv
rtl/irq_handshake.sv
rtl/kernel_helper.sv
tests/tb_kernel_helper.sv

// ==== Makefile ====
# Verilator build and run for the kernel helper testbench

SIM      ?= verilator
VFLAGS   ?= --binary --timing -Wno-fatal -j 0
TOP      ?= tb_kernel_helper
FILELIST ?= filelist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG  = NO ERRORS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
